// ==== all.f ====
source/cpuPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardControl.sv
source/proc.sv
sim/procTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := procTb
FILELIST  := all.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJDIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== sim/procTb.sv ====
//**************************************************************************
// Testbench for the pipelined processor with an instruction-set model
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module procTb;
    import cpuPkg::*;

    localparam int StepLimit    = 2000;
    localparam int RunTimeout   = 4000;
    localparam int LoadTimeout  = 20;
    localparam int DrainTimeout = 20;
    localparam int OutNone      = 0;
    localparam int OutHalt      = 1;
    localparam int OutError     = 2;

    logic      clk;
    logic      rstN;
    progLoad_t progLoad;
    logic      loadValid;
    logic      start;
    logic      loadReady;
    retire_t   retire;
    logic      halted;
    logic      err;

    integer               seed;
    logic [DataWidth-1:0] prog [ImemDepth];
    int                   progLen;
    retire_t              expQ [$];
    logic [DataWidth-1:0] modelRegs [RegCount];
    logic [DataWidth-1:0] modelMem [DmemDepth];

    proc dut (
        .clk(clk), .rstN(rstN), .progLoad(progLoad), .loadValid(loadValid),
        .start(start), .loadReady(loadReady), .retire(retire),
        .halted(halted), .err(err)
    );

    always #5 clk = ~clk;

    function automatic void abortRun(input string why);
        $display("Some tests failed");
        $fatal(1, "%s", why);
    endfunction

    // Instruction encoders with the opcode in 15:11 then rs, rt and rd
    function automatic logic [DataWidth-1:0] encR(input opcode_e op, input int rs,
                                                   input int rt, input int rd);
        return {op, 3'(rs), 3'(rt), 3'(rd), 2'b00};
    endfunction

    function automatic logic [DataWidth-1:0] encI(input opcode_e op, input int rs,
                                                   input int rt, input int imm);
        return {op, 3'(rs), 3'(rt), 5'(imm)};
    endfunction

    function automatic logic [DataWidth-1:0] encB(input int rs, input int off);
        return {OpBeqz, 3'(rs), 8'(off)};
    endfunction

    function automatic logic [DataWidth-1:0] encOp(input opcode_e op);
        return {op, 11'd0};
    endfunction

    function automatic int randBelow(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    function automatic opcode_e randAluOp();
        case (randBelow(4))
            0: return OpAdd;
            1: return OpSub;
            2: return OpAnd;
            default: return OpXor;
        endcase
    endfunction

    // Unused words stay HALT so a stray fetch cannot run on
    task automatic newProgram();
        for (int i = 0; i < ImemDepth; i++) begin
            prog[i] = encOp(OpHalt);
        end
        progLen = 0;
    endtask

    task automatic emit(input logic [DataWidth-1:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic buildRandomProgram();
        int len;
        newProgram();
        len = 16 + randBelow(16);
        for (int i = 0; i < len; i++) begin
            case (randBelow(6))
                1: emit(encR(randAluOp(), randBelow(RegCount), randBelow(RegCount),
                             randBelow(RegCount)));
                2: emit(encI(OpLd, randBelow(RegCount), randBelow(RegCount),
                             randBelow(32) - 16));
                3: emit(encI(OpSt, randBelow(RegCount), randBelow(RegCount),
                             randBelow(32) - 16));
                4: begin
                    // Forward only and landing at most on the final HALT
                    if (len - i > 1) begin
                        emit(encB(randBelow(RegCount), 1 + randBelow(len - i - 1)));
                    end else begin
                        emit(encOp(OpNop));
                    end
                end
                default: emit(encI(OpAddi, randBelow(RegCount), randBelow(RegCount),
                                   randBelow(32) - 16));
            endcase
        end
        emit(encOp(OpHalt));
    endtask

    function automatic retire_t makeRetire(input retireKind_e kind,
                                           input logic [DmemAddrWidth-1:0] index,
                                           input logic [DataWidth-1:0] data);
        retire_t r;
        r.valid = 1'b1;
        r.kind  = kind;
        r.index = index;
        r.data  = data;
        return r;
    endfunction

    function automatic void writeReg(input logic [RegIdxWidth-1:0] idx,
                                     input logic [DataWidth-1:0] val);
        modelRegs[idx] = val;
        expQ.push_back(makeRetire(RetReg, DmemAddrWidth'(idx), val));
    endfunction

    // Architectural model of the instruction set, fills expQ
    function automatic int runModel();
        logic [DataWidth-1:0]     pc;
        logic [DataWidth-1:0]     instr;
        logic [DataWidth-1:0]     imm;
        logic [DataWidth-1:0]     off;
        logic [DataWidth-1:0]     a;
        logic [DataWidth-1:0]     b;
        logic [RegIdxWidth-1:0]   rs;
        logic [RegIdxWidth-1:0]   rt;
        logic [RegIdxWidth-1:0]   rd;
        logic [DmemAddrWidth-1:0] addr;
        expQ.delete();
        for (int i = 0; i < RegCount; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < DmemDepth; i++) begin
            modelMem[i] = '0;
        end
        pc = '0;
        for (int step = 0; step < StepLimit; step++) begin
            instr = prog[pc[ImemAddrWidth-1:0]];
            rs    = instr[10:8];
            rt    = instr[7:5];
            rd    = instr[4:2];
            imm   = {{11{instr[4]}}, instr[4:0]};
            off   = {{8{instr[7]}}, instr[7:0]};
            a     = modelRegs[rs];
            b     = modelRegs[rt];
            addr  = DmemAddrWidth'(a + imm);
            pc    = pc + 16'd1;
            case (instr[15:11])
                OpNop: ;
                OpAdd: writeReg(rd, a + b);
                OpSub: writeReg(rd, a - b);
                OpAnd: writeReg(rd, a & b);
                OpXor: writeReg(rd, a ^ b);
                OpAddi: writeReg(rt, a + imm);
                OpLd: writeReg(rt, modelMem[addr]);
                OpSt: begin
                    modelMem[addr] = b;
                    expQ.push_back(makeRetire(RetStore, addr, b));
                end
                OpBeqz: begin
                    if (a == '0) begin
                        pc = pc + off;
                    end
                end
                OpHalt: return OutHalt;
                default: return OutError;
            endcase
        end
        return OutNone;
    endfunction

    task automatic checkRetire(input retire_t expected, input retire_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: retire expected kind=%b index=%0d data=%h, %s",
                     $time, expected.kind, expected.index, expected.data,
                     $sformatf("actual kind=%b index=%0d data=%h",
                               actual.kind, actual.index, actual.data));
            abortRun("retire entry differs from the model");
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %b actual %b",
                     $time, name, expected, actual);
            abortRun($sformatf("%s has the wrong value", name));
        end
    endtask

    // Retire is combinational from registers and stable at the falling edge
    always @(negedge clk) begin
        if (rstN && retire.valid) begin
            if (expQ.size() == 0) begin
                abortRun($sformatf("retire entry at %0t ns that the model does not expect",
                                   $time));
            end else begin
                checkRetire(expQ.pop_front(), retire);
            end
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic applyReset();
        rstN      = 1'b0;
        loadValid = 1'b0;
        start     = 1'b0;
        repeat (5) nextCycle();
        rstN = 1'b1;
        nextCycle();
    endtask

    task automatic loadProgram();
        int waitCycles;
        for (int a = 0; a < ImemDepth; a++) begin
            progLoad.addr  = ImemAddrWidth'(a);
            progLoad.instr = prog[a];
            loadValid      = 1'b1;
            waitCycles     = 0;
            while (!loadReady) begin
                if (waitCycles >= LoadTimeout) begin
                    abortRun("timeout waiting for loadReady");
                end
                nextCycle();
                waitCycles++;
            end
            nextCycle();
        end
        loadValid = 1'b0;
    endtask

    task automatic runCase(input string name);
        int outcome;
        int cycles;
        $display("Running %s", name);
        applyReset();
        loadProgram();
        outcome = runModel();
        if (outcome == OutNone) begin
            abortRun($sformatf("model of %s reaches neither HALT nor an illegal opcode", name));
        end
        start = 1'b1;
        nextCycle();
        start = 1'b0;
        cycles = 0;
        while (!(halted || err)) begin
            if (cycles >= RunTimeout) begin
                abortRun($sformatf("timeout waiting for halted or err in %s", name));
            end
            nextCycle();
            cycles++;
        end
        // Older instructions may still be draining after err
        cycles = 0;
        while (expQ.size() != 0) begin
            if (cycles >= DrainTimeout) begin
                abortRun($sformatf("expected retire entries missing in %s", name));
            end
            nextCycle();
            cycles++;
        end
        repeat (5) nextCycle();
        checkFlag("halted", outcome == OutHalt, halted);
        checkFlag("err", outcome == OutError, err);
        checkFlag("loadReady", 1'b0, loadReady);
    endtask

    initial begin
        seed      = 16490;
        clk       = 1'b0;
        rstN      = 1'b0;
        progLoad  = '0;
        loadValid = 1'b0;
        start     = 1'b0;

        // Back-to-back ALU dependencies
        newProgram();
        emit(encI(OpAddi, 0, 1, 5));
        emit(encI(OpAddi, 1, 2, -3));
        emit(encR(OpAdd, 1, 2, 3));
        emit(encR(OpSub, 3, 1, 4));
        emit(encR(OpAnd, 4, 3, 5));
        emit(encR(OpXor, 5, 4, 6));
        emit(encR(OpAdd, 6, 6, 0));
        emit(encR(OpSub, 0, 1, 7));
        emit(encOp(OpHalt));
        runCase("ALU forwarding");

        // Stores, loads and load-use pairs
        newProgram();
        emit(encI(OpAddi, 0, 1, 9));
        emit(encI(OpAddi, 0, 2, 12));
        emit(encI(OpSt, 2, 1, 0));
        emit(encI(OpSt, 2, 2, 3));
        emit(encI(OpLd, 2, 3, 0));
        emit(encR(OpAdd, 3, 3, 4));
        emit(encI(OpLd, 2, 5, 3));
        emit(encI(OpSt, 5, 5, -1));
        emit(encI(OpLd, 5, 6, -1));
        emit(encR(OpXor, 6, 5, 7));
        emit(encOp(OpHalt));
        runCase("load and store");

        // Countdown loop that exits to 6 and branches back to 2
        newProgram();
        emit(encI(OpAddi, 0, 1, 4));
        emit(encI(OpAddi, 0, 2, 0));
        emit(encB(1, 3));
        emit(encI(OpAddi, 2, 2, 3));
        emit(encI(OpAddi, 1, 1, -1));
        emit(encB(0, -4));
        emit(encI(OpSt, 0, 2, 1));
        emit(encOp(OpHalt));
        emit(encI(OpAddi, 0, 3, 7));
        runCase("countdown loop");

        newProgram();
        emit(encI(OpAddi, 0, 1, 1));
        emit(encI(OpAddi, 1, 2, 1));
        emit(encOp(OpHalt));
        emit(encI(OpAddi, 0, 3, 3));
        emit(encI(OpSt, 0, 3, 2));
        runCase("halt");

        // Opcode 5'h1F is undefined
        newProgram();
        emit(encI(OpAddi, 0, 1, 3));
        emit(encI(OpAddi, 1, 2, 1));
        emit(encR(OpAdd, 1, 2, 3));
        emit(16'hF800);
        emit(encI(OpAddi, 0, 4, 4));
        emit(encOp(OpHalt));
        runCase("illegal opcode");

        for (int n = 0; n < 20; n++) begin
            buildRandomProgram();
            runCase($sformatf("random program %0d", n));
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/proc.sv ====
//**************************************************************************
// Five-stage pipelined 16-bit processor top level
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module proc (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::progLoad_t  progLoad,
    input  logic               loadValid,
    input  logic               start,
    output logic               loadReady,
    output cpuPkg::retire_t    retire,
    output logic               halted,
    output logic               err
);
    import cpuPkg::*;

    ifId_t                  ifId;
    idEx_t                  idEx;
    exMem_t                 exMem;
    memWb_t                 memWb;
    logic [RegIdxWidth-1:0] rsIdx;
    logic [RegIdxWidth-1:0] rtIdx;
    logic                   run;
    logic                   stall;
    logic                   flush;
    logic [1:0]             fwdA;
    logic [1:0]             fwdB;
    logic                   branchTaken;
    logic [DataWidth-1:0]   branchTarget;

    fetchStage fetch0 (
        .clk(clk), .rstN(rstN), .progLoad(progLoad), .loadValid(loadValid),
        .start(start), .run(run), .stall(stall), .flush(flush),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .loadReady(loadReady), .ifId(ifId)
    );

    decodeStage decode0 (
        .clk(clk), .rstN(rstN), .ifId(ifId), .stall(stall), .flush(flush),
        .wb(memWb), .idEx(idEx), .rsIdx(rsIdx), .rtIdx(rtIdx)
    );

    // Forwarding sources are the EX/MEM result and the writeback data
    executeStage exec0 (
        .clk(clk), .rstN(rstN), .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
        .exMemFwd(exMem.aluResult), .wbData(memWb.data),
        .exMem(exMem), .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    memoryStage mem0 (
        .clk(clk), .rstN(rstN), .exMem(exMem), .memWb(memWb), .retire(retire)
    );

    hazardControl hzd0 (
        .clk(clk), .rstN(rstN), .start(start), .rsIdx(rsIdx), .rtIdx(rtIdx),
        .idEx(idEx), .exMem(exMem), .memWb(memWb), .branchTaken(branchTaken),
        .run(run), .stall(stall), .flush(flush), .fwdA(fwdA), .fwdB(fwdB),
        .halted(halted), .err(err)
    );

endmodule

`default_nettype wire

// ==== source/hazardControl.sv ====
//**************************************************************************
// Hazard control: load-use stall, forwarding, flushes and run/halt/error
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module hazardControl (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             start,
    input  logic [cpuPkg::RegIdxWidth-1:0]   rsIdx,
    input  logic [cpuPkg::RegIdxWidth-1:0]   rtIdx,
    input  cpuPkg::idEx_t                    idEx,
    input  cpuPkg::exMem_t                   exMem,
    input  cpuPkg::memWb_t                   memWb,
    input  logic                             branchTaken,
    output logic                             run,
    output logic                             stall,
    output logic                             flush,
    output logic [1:0]                       fwdA,
    output logic [1:0]                       fwdB,
    output logic                             halted,
    output logic                             err
);
    import cpuPkg::*;

    logic stopNow;

    // Newest producer wins with EX/MEM ahead of writeback
    function automatic logic [1:0] fwdSel(input logic [RegIdxWidth-1:0] src);
        if (exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memRead &&
            exMem.ctrl.dst == src) begin
            return FwdExMem;
        end
        if (memWb.valid && memWb.regWrite && memWb.dst == src) begin
            return FwdWb;
        end
        return FwdReg;
    endfunction

    always_comb begin
        fwdA = fwdSel(idEx.rs);
        fwdB = fwdSel(idEx.rt);
    end

    // Load in execute feeding the instruction in decode
    assign stall = idEx.valid && idEx.ctrl.memRead &&
                   (idEx.ctrl.dst == rsIdx || idEx.ctrl.dst == rtIdx);

    // HALT or illegal in execute kills everything younger
    assign stopNow = idEx.valid && (idEx.ctrl.halt || idEx.ctrl.illegal);
    assign flush   = branchTaken || stopNow;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            run    <= 1'b0;
            halted <= 1'b0;
            err    <= 1'b0;
        end else begin
            if (start) begin
                run <= 1'b1;
            end else if (stopNow) begin
                run <= 1'b0;
            end
            // HALT is entering writeback
            if (exMem.valid && exMem.ctrl.halt) begin
                halted <= 1'b1;
            end
            if (idEx.valid && idEx.ctrl.illegal) begin
                err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/memoryStage.sv ====
//**************************************************************************
// Memory stage: data memory, MEM/WB register and the retire trace output
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module memoryStage (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::exMem_t  exMem,
    output cpuPkg::memWb_t  memWb,
    output cpuPkg::retire_t retire
);
    import cpuPkg::*;

    logic [DataWidth-1:0]     dmem [DmemDepth];
    logic [DmemAddrWidth-1:0] addr;
    logic                     doStore;
    logic                     storeQ;
    logic [DmemAddrWidth-1:0] storeAddrQ;
    logic [DataWidth-1:0]     storeDataQ;

    assign addr    = exMem.aluResult[DmemAddrWidth-1:0];
    assign doStore = exMem.valid && exMem.ctrl.memWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DmemDepth; i++) begin
                dmem[i] <= '0;
            end
        end else if (doStore) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    // Store details ride along so the trace shows them at writeback
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb      <= '0;
            storeQ     <= 1'b0;
            storeAddrQ <= '0;
            storeDataQ <= '0;
        end else begin
            memWb <= '{
                valid:    exMem.valid,
                regWrite: exMem.ctrl.regWrite,
                dst:      exMem.ctrl.dst,
                data:     exMem.ctrl.memRead ? dmem[addr] : exMem.aluResult
            };
            storeQ     <= doStore;
            storeAddrQ <= addr;
            storeDataQ <= exMem.storeData;
        end
    end

    always_comb begin
        retire = '0;
        if (memWb.valid && memWb.regWrite) begin
            retire.valid = 1'b1;
            retire.kind  = RetReg;
            retire.index = DmemAddrWidth'(memWb.dst);
            retire.data  = memWb.data;
        end else if (storeQ) begin
            retire.valid = 1'b1;
            retire.kind  = RetStore;
            retire.index = storeAddrQ;
            retire.data  = storeDataQ;
        end
    end

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
//**************************************************************************
// Execute stage: operand forwarding, ALU, branch resolve and EX/MEM register
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  logic                           clk,
    input  logic                           rstN,
    input  cpuPkg::idEx_t                  idEx,
    input  logic [1:0]                     fwdA,
    input  logic [1:0]                     fwdB,
    input  logic [cpuPkg::DataWidth-1:0]   exMemFwd,
    input  logic [cpuPkg::DataWidth-1:0]   wbData,
    output cpuPkg::exMem_t                 exMem,
    output logic                           branchTaken,
    output logic [cpuPkg::DataWidth-1:0]   branchTarget
);
    import cpuPkg::*;

    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;
    logic [DataWidth-1:0] aluB;
    logic [DataWidth-1:0] aluResult;

    function automatic logic [DataWidth-1:0] pickOperand(
        input logic [1:0]           sel,
        input logic [DataWidth-1:0] regVal
    );
        case (sel)
            FwdExMem: return exMemFwd;
            FwdWb:    return wbData;
            default:  return regVal;
        endcase
    endfunction

    always_comb begin
        opA = pickOperand(fwdA, idEx.opA);
        opB = pickOperand(fwdB, idEx.opB);
    end

    assign aluB = idEx.ctrl.useImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            AluAdd:  aluResult = opA + aluB;
            AluSub:  aluResult = opA - aluB;
            AluAnd:  aluResult = opA & aluB;
            default: aluResult = opA ^ aluB;
        endcase
    end

    // BEQZ tests the forwarded rs and targets PC+1 plus the offset
    assign branchTaken  = idEx.valid && idEx.ctrl.branch && (opA == '0);
    assign branchTarget = idEx.pc + DataWidth'(1) + idEx.imm;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem <= '{
                valid:     idEx.valid,
                ctrl:      idEx.ctrl,
                aluResult: aluResult,
                storeData: opB
            };
        end
    end

endmodule

`default_nettype wire

// ==== source/decodeStage.sv ====
//**************************************************************************
// Decode stage: control decoding, register file, immediates, ID/EX register
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  logic                             clk,
    input  logic                             rstN,
    input  cpuPkg::ifId_t                    ifId,
    input  logic                             stall,
    input  logic                             flush,
    input  cpuPkg::memWb_t                   wb,
    output cpuPkg::idEx_t                    idEx,
    output logic [cpuPkg::RegIdxWidth-1:0]   rsIdx,
    output logic [cpuPkg::RegIdxWidth-1:0]   rtIdx
);
    import cpuPkg::*;

    logic [DataWidth-1:0]   regs [RegCount];
    logic [4:0]             opField;
    logic [RegIdxWidth-1:0] rdIdx;
    logic [DataWidth-1:0]   imm;
    logic [DataWidth-1:0]   rsData;
    logic [DataWidth-1:0]   rtData;
    logic                   wbWrite;
    ctrl_t                  ctrl;

    assign opField = ifId.instr[DataWidth-1:OpcodeLsb];
    assign rsIdx   = ifId.instr[RsLsb +: RegIdxWidth];
    assign rtIdx   = ifId.instr[RtLsb +: RegIdxWidth];
    assign rdIdx   = ifId.instr[RdLsb +: RegIdxWidth];

    always_comb begin
        ctrl     = '0;
        ctrl.dst = rtIdx;
        case (opField)
            OpNop: ;
            OpAdd, OpSub, OpAnd, OpXor: begin
                ctrl.aluOp    = aluOp_e'(opField[1:0]);
                ctrl.regWrite = 1'b1;
                ctrl.dst      = rdIdx;
            end
            OpAddi: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OpLd: begin
                ctrl.useImm   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OpSt: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OpBeqz: ctrl.branch = 1'b1;
            OpHalt: ctrl.halt = 1'b1;
            default: ctrl.illegal = 1'b1;
        endcase
    end

    // BEQZ carries an 8-bit offset, the others a 5-bit immediate
    assign imm = (opField == OpBeqz) ?
        {{(DataWidth-OffsetWidth){ifId.instr[OffsetWidth-1]}}, ifId.instr[OffsetWidth-1:0]} :
        {{(DataWidth-ImmWidth){ifId.instr[ImmWidth-1]}}, ifId.instr[ImmWidth-1:0]};

    // Write-through so a same-cycle writeback is seen here
    assign wbWrite = wb.valid && wb.regWrite;
    assign rsData  = (wbWrite && wb.dst == rsIdx) ? wb.data : regs[rsIdx];
    assign rtData  = (wbWrite && wb.dst == rtIdx) ? wb.data : regs[rtIdx];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[wb.dst] <= wb.data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (stall || flush) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx <= '{
                valid: ifId.valid,
                ctrl:  ctrl,
                pc:    ifId.pc,
                rs:    rsIdx,
                rt:    rtIdx,
                opA:   rsData,
                opB:   rtData,
                imm:   imm
            };
        end
    end

endmodule

`default_nettype wire

// ==== source/fetchStage.sv ====
//**************************************************************************
// Fetch stage: instruction memory with its load port, PC and IF/ID register
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
    input  logic                           clk,
    input  logic                           rstN,
    input  cpuPkg::progLoad_t              progLoad,
    input  logic                           loadValid,
    input  logic                           start,
    input  logic                           run,
    input  logic                           stall,
    input  logic                           flush,
    input  logic                           branchTaken,
    input  logic [cpuPkg::DataWidth-1:0]   branchTarget,
    output logic                           loadReady,
    output cpuPkg::ifId_t                  ifId
);
    import cpuPkg::*;

    logic [DataWidth-1:0] imem [ImemDepth];
    logic [DataWidth-1:0] pc;

    // Program words arrive only while the core is idle
    always_ff @(posedge clk) begin
        if (loadValid && loadReady) begin
            imem[progLoad.addr] <= progLoad.instr;
        end
    end

    // Idle until start, then the PC counts or follows a taken branch
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            loadReady <= 1'b1;
            pc        <= '0;
        end else if (start && loadReady) begin
            loadReady <= 1'b0;
            pc        <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (run && !stall) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifId <= '0;
        end else if (flush) begin
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            ifId <= '{
                valid: run,
                pc:    pc,
                instr: imem[pc[ImemAddrWidth-1:0]]
            };
        end
    end

endmodule

`default_nettype wire

// ==== source/cpuPkg.sv ====
//**************************************************************************
// CPU package: sizes, opcodes, instruction fields and pipeline stage types
//**************************************************************************
`default_nettype none

package cpuPkg;

    localparam int DataWidth     = 16;
    localparam int RegCount      = 8;
    localparam int RegIdxWidth   = 3;
    localparam int ImemDepth     = 64;
    localparam int DmemDepth     = 64;
    localparam int ImemAddrWidth = 6;
    localparam int DmemAddrWidth = 6;

    // Lowest bit of each instruction field
    localparam int OpcodeLsb = 11;
    localparam int RsLsb     = 8;
    localparam int RtLsb     = 5;
    localparam int RdLsb     = 2;

    // Immediate of ADDI/LD/ST and offset of BEQZ
    localparam int ImmWidth    = 5;
    localparam int OffsetWidth = 8;

    // Operand source selects
    localparam logic [1:0] FwdReg   = 2'd0;
    localparam logic [1:0] FwdExMem = 2'd1;
    localparam logic [1:0] FwdWb    = 2'd2;

    // ALU ops share 5'b001xx so the low bits give the ALU operation
    typedef enum logic [4:0] {
        OpNop  = 5'h00,
        OpAdd  = 5'h04,
        OpSub  = 5'h05,
        OpAnd  = 5'h06,
        OpXor  = 5'h07,
        OpAddi = 5'h08,
        OpLd   = 5'h09,
        OpSt   = 5'h0A,
        OpBeqz = 5'h0C,
        OpHalt = 5'h01
    } opcode_e;

    typedef enum logic [1:0] {
        AluAdd = 2'd0,
        AluSub = 2'd1,
        AluAnd = 2'd2,
        AluXor = 2'd3
    } aluOp_e;

    typedef struct packed {
        aluOp_e                 aluOp;
        logic                   useImm;
        logic                   memRead;
        logic                   memWrite;
        logic                   regWrite;
        logic                   branch;
        logic                   halt;
        logic                   illegal;
        logic [RegIdxWidth-1:0] dst;
    } ctrl_t;

    typedef struct packed {
        logic                 valid;
        logic [DataWidth-1:0] pc;
        logic [DataWidth-1:0] instr;
    } ifId_t;

    typedef struct packed {
        logic                   valid;
        ctrl_t                  ctrl;
        logic [DataWidth-1:0]   pc;
        logic [RegIdxWidth-1:0] rs;
        logic [RegIdxWidth-1:0] rt;
        logic [DataWidth-1:0]   opA;
        logic [DataWidth-1:0]   opB;
        logic [DataWidth-1:0]   imm;
    } idEx_t;

    typedef struct packed {
        logic                 valid;
        ctrl_t                ctrl;
        logic [DataWidth-1:0] aluResult;
        logic [DataWidth-1:0] storeData;
    } exMem_t;

    typedef struct packed {
        logic                   valid;
        logic                   regWrite;
        logic [RegIdxWidth-1:0] dst;
        logic [DataWidth-1:0]   data;
    } memWb_t;

    typedef struct packed {
        logic [ImemAddrWidth-1:0] addr;
        logic [DataWidth-1:0]     instr;
    } progLoad_t;

    typedef enum logic {
        RetReg   = 1'b0,
        RetStore = 1'b1
    } retireKind_e;

    // Index is the register number or the store address
    typedef struct packed {
        logic                     valid;
        retireKind_e              kind;
        logic [DmemAddrWidth-1:0] index;
        logic [DataWidth-1:0]     data;
    } retire_t;

endpackage

`default_nettype wire
